//--- rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    localparam logic [XLEN-1:0] RESET_PC  = 32'h8000_0000;
    localparam logic [XLEN-1:0] DMEM_BASE = 32'h8000_1000;
    localparam int              DMEM_WORDS = 256;

    // major opcodes, FENCE is left out on purpose
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    localparam logic [XLEN-1:0] MSTATUS_RESET = 32'h0000_1800; // MPP = machine
    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        OPA_RS1,
        OPA_PC,
        OPA_ZERO
    } op_a_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4,
        WB_CSR
    } wb_sel_e;

    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_WRITE,
        CSR_SET
    } csr_op_e;

endpackage

//--- instr_decode.sv
`timescale 1ns/10ps

module instr_decode import rv_pkg::*; (
    input  logic [31:0]     inst,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic [4:0]      rd,
    output logic [31:0]     imm,
    output alu_op_e         alu_op,
    output op_a_sel_e       op_a_sel,
    output logic            op_b_imm,
    output wb_sel_e         wb_sel,
    output logic            reg_wen,
    output logic            mem_ren,
    output logic            mem_wen,
    output logic            branch,
    output logic            jump,
    output logic            jalr,
    output logic [2:0]      mem_funct3,
    output csr_op_e         csr_op,
    output logic [11:0]     csr_addr,
    output logic            ecall,
    output logic            mret,
    output logic            ebreak,
    output logic            illegal
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic            wen_raw;

    assign opcode     = inst[6:0];
    assign funct3     = inst[14:12];
    assign funct7     = inst[31:25];
    assign rd         = inst[11:7];
    assign rs1        = inst[19:15];
    assign rs2        = inst[24:20];
    assign mem_funct3 = funct3;   // also selects the branch condition
    assign csr_addr   = inst[31:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct3 picks the operation, alt selects SUB and SRA
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        imm      = imm_i;
        alu_op   = ALU_ADD;
        op_a_sel = OPA_ZERO;   // the ALU idles on zero unless rs1 or pc is needed
        op_b_imm = 1'b1;
        wb_sel   = WB_ALU;
        wen_raw  = 1'b0;
        mem_ren  = 1'b0;
        mem_wen  = 1'b0;
        branch   = 1'b0;
        jump     = 1'b0;
        jalr     = 1'b0;
        csr_op   = CSR_NONE;
        ecall    = 1'b0;
        mret     = 1'b0;
        ebreak   = 1'b0;
        illegal  = 1'b0;
        case (opcode)
            OP_LUI: begin
                imm     = imm_u;
                alu_op  = ALU_PASS_B;
                wen_raw = 1'b1;
            end
            OP_AUIPC: begin
                imm      = imm_u;
                op_a_sel = OPA_PC;
                wen_raw  = 1'b1;
            end
            OP_JAL: begin
                imm      = imm_j;
                op_a_sel = OPA_PC;   // target is pc + offset
                wb_sel   = WB_PC4;
                jump     = 1'b1;
                wen_raw  = 1'b1;
            end
            OP_JALR: begin
                op_a_sel = OPA_RS1;
                wb_sel   = WB_PC4;
                jump     = 1'b1;
                jalr     = 1'b1;
                wen_raw  = 1'b1;
                illegal  = (funct3 != 3'b000);
            end
            OP_BRANCH: begin
                imm     = imm_b;
                branch  = 1'b1;
                illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            OP_LOAD: begin
                op_a_sel = OPA_RS1;
                wb_sel   = WB_MEM;
                mem_ren  = 1'b1;
                wen_raw  = 1'b1;
                illegal  = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            OP_STORE: begin
                imm      = imm_s;
                op_a_sel = OPA_RS1;
                mem_wen  = 1'b1;
                illegal  = (funct3 > 3'b010);
            end
            OP_IMM: begin
                op_a_sel = OPA_RS1;
                alu_op   = alu_sel(funct3, (funct3 == 3'b101) && funct7[5]);
                wen_raw  = 1'b1;
                if (funct3 == 3'b001) begin
                    illegal = (funct7 != 7'b0);
                end else if (funct3 == 3'b101) begin
                    illegal = (funct7 != 7'b0) && (funct7 != 7'b0100000);
                end
            end
            OP_REG: begin
                op_a_sel = OPA_RS1;
                op_b_imm = 1'b0;
                alu_op   = alu_sel(funct3, funct7[5]);
                wen_raw  = 1'b1;
                illegal  = (funct7 != 7'b0) &&
                           !((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OP_SYSTEM: begin
                case (funct3)
                    3'b000: begin
                        ecall   = (inst == 32'h0000_0073);
                        ebreak  = (inst == 32'h0010_0073);
                        mret    = (inst == 32'h3020_0073);
                        illegal = !(ecall || ebreak || mret);
                    end
                    3'b001, 3'b010: begin
                        csr_op  = (funct3 == 3'b001) ? CSR_WRITE : CSR_SET;
                        wb_sel  = WB_CSR;
                        wen_raw = 1'b1;
                    end
                    default: illegal = 1'b1;   // immediate CSR forms are not supported
                endcase
            end
            default: illegal = 1'b1;
        endcase
    end

    assign reg_wen = wen_raw && (rd != 5'd0);

endmodule

//--- reg_file.sv
`timescale 1ns/10ps

module reg_file import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic [XLEN-1:0] rd_wdata,
    input  logic            wen,
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data,
    output logic [XLEN-1:0] a0_data
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[rd] <= rd_wdata;
        end
    end

    // x0 keeps its reset value since the decoder never enables a write to it
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];
    assign a0_data  = regs[10];

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((rs1 != 5'd0) || (rs1_data == '0)) && ((rs2 != 5'd0) || (rs2_data == '0)));

endmodule

//--- exec_unit.sv
`timescale 1ns/10ps

module exec_unit import rv_pkg::*; (
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] imm,
    input  alu_op_e         alu_op,
    input  op_a_sel_e       op_a_sel,
    input  logic            op_b_imm,
    input  logic [2:0]      branch_funct3,
    output logic [XLEN-1:0] result,
    output logic            branch_taken
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    always_comb begin
        case (op_a_sel)
            OPA_RS1: op_a = rs1_data;
            OPA_PC:  op_a = pc;
            default: op_a = '0;
        endcase
    end

    assign op_b  = op_b_imm ? imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   result = {31'b0, op_a < op_b};
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    // only meaningful for branches, the core qualifies it
    always_comb begin
        case (branch_funct3)
            3'b000:  branch_taken = (rs1_data == rs2_data);
            3'b001:  branch_taken = (rs1_data != rs2_data);
            3'b100:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  branch_taken = (rs1_data < rs2_data);
            3'b111:  branch_taken = (rs1_data >= rs2_data);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

//--- data_mem.sv
`timescale 1ns/10ps

module data_mem import rv_pkg::*; (
    input  logic            clk,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] wdata,
    input  logic            ren,
    input  logic            wen,
    input  logic [2:0]      funct3,
    output logic [XLEN-1:0] rdata
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [XLEN-1:0] mem [DMEM_WORDS];
    logic [XLEN-1:0] offset;
    logic [AW-1:0]   idx;
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] wdata_sh;
    logic [3:0]      be;
    logic [XLEN-1:0] rdata_sh;

    assign offset = addr - DMEM_BASE;
    assign idx    = offset[AW+1:2];
    assign word   = mem[idx];

    // move the store data onto its byte lanes and enable only those
    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                wdata_sh = wdata << (8 * addr[1:0]);
                be       = 4'b0001 << addr[1:0];
            end
            2'b01: begin
                wdata_sh = wdata << (16 * addr[1]);
                be       = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata_sh = wdata;
                be       = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) mem[idx][8*i +: 8] <= wdata_sh[8*i +: 8];
            end
        end
    end

    assign rdata_sh = word >> (8 * addr[1:0]);

    always_comb begin
        case (funct3)
            3'b000:  rdata = {{24{rdata_sh[7]}}, rdata_sh[7:0]};
            3'b001:  rdata = {{16{rdata_sh[15]}}, rdata_sh[15:0]};
            3'b100:  rdata = {24'b0, rdata_sh[7:0]};
            3'b101:  rdata = {16'b0, rdata_sh[15:0]};
            default: rdata = word;
        endcase
    end

    a_addr_range: assert property (@(posedge clk)
        (ren || wen) |-> (offset < XLEN'(DMEM_WORDS * 4)));

endmodule

//--- csr_unit.sv
`timescale 1ns/10ps

module csr_unit import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  csr_op_e         csr_op,
    input  logic [11:0]     csr_addr,
    input  logic [XLEN-1:0] csr_wdata,
    input  logic [XLEN-1:0] pc,
    input  logic            ecall,
    output logic [XLEN-1:0] csr_rdata,
    output logic [XLEN-1:0] mtvec,
    output logic [XLEN-1:0] mepc
);

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] csr_new;

    always_comb begin
        case (csr_addr)
            CSR_MSTATUS: csr_rdata = mstatus;
            CSR_MTVEC:   csr_rdata = mtvec;
            CSR_MEPC:    csr_rdata = mepc;
            CSR_MCAUSE:  csr_rdata = mcause;
            default:     csr_rdata = '0;   // unknown CSRs read as zero
        endcase
    end

    assign csr_new = (csr_op == CSR_WRITE) ? csr_wdata : (csr_rdata | csr_wdata);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus <= MSTATUS_RESET;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (ecall) begin
            mepc   <= pc;   // the handler steps past the ECALL itself
            mcause <= CAUSE_ECALL_M;
        end else if (csr_op != CSR_NONE) begin
            case (csr_addr)
                CSR_MSTATUS: mstatus <= csr_new;
                CSR_MTVEC:   mtvec   <= csr_new;
                CSR_MEPC:    mepc    <= csr_new;
                CSR_MCAUSE:  mcause  <= csr_new;
                default:     ;
            endcase
        end
    end

endmodule

//--- cpu_core.sv
`timescale 1ns/10ps

module cpu_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [XLEN-1:0] imem_data,
    output logic [XLEN-1:0] imem_addr,
    output logic [XLEN-1:0] retire_pc,
    output logic [XLEN-1:0] wb_data,
    output logic [XLEN-1:0] exit_code,
    output logic            retire_valid,
    output logic            wb_en,
    output logic            halted,
    output logic [4:0]      wb_rd
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] next_pc;
    logic            active;

    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    op_a_sel_e       op_a_sel;
    logic            op_b_imm;
    wb_sel_e         wb_sel;
    logic            reg_wen;
    logic            mem_ren;
    logic            mem_wen;
    logic            branch;
    logic            jump;
    logic            jalr;
    logic [2:0]      funct3;
    csr_op_e         csr_op;
    csr_op_e         csr_op_act;
    logic [11:0]     csr_addr;
    logic            ecall;
    logic            mret;
    logic            ebreak;
    logic            illegal;

    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] a0_data;
    logic [XLEN-1:0] alu_result;
    logic            branch_taken;
    logic [XLEN-1:0] mem_rdata;
    logic [XLEN-1:0] csr_rdata;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;

    assign active     = rst_n && !halted;   // one instruction commits per cycle when set
    assign pc_plus4   = pc + 32'd4;
    assign csr_op_act = active ? csr_op : CSR_NONE;

    instr_decode instr_decode_inst (
        .inst       (imem_data),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .imm        (imm),
        .alu_op     (alu_op),
        .op_a_sel   (op_a_sel),
        .op_b_imm   (op_b_imm),
        .wb_sel     (wb_sel),
        .reg_wen    (reg_wen),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .branch     (branch),
        .jump       (jump),
        .jalr       (jalr),
        .mem_funct3 (funct3),
        .csr_op     (csr_op),
        .csr_addr   (csr_addr),
        .ecall      (ecall),
        .mret       (mret),
        .ebreak     (ebreak),
        .illegal    (illegal)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .rd_wdata (wb_data),
        .wen      (wb_en),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .a0_data  (a0_data)
    );

    exec_unit exec_unit_inst (
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .imm           (imm),
        .alu_op        (alu_op),
        .op_a_sel      (op_a_sel),
        .op_b_imm      (op_b_imm),
        .branch_funct3 (funct3),
        .result        (alu_result),
        .branch_taken  (branch_taken)
    );

    data_mem data_mem_inst (
        .clk    (clk),
        .addr   (alu_result),
        .wdata  (rs2_data),
        .ren    (mem_ren && active),
        .wen    (mem_wen && active),
        .funct3 (funct3),
        .rdata  (mem_rdata)
    );

    csr_unit csr_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_op    (csr_op_act),
        .csr_addr  (csr_addr),
        .csr_wdata (rs1_data),
        .pc        (pc),
        .ecall     (ecall && active),
        .csr_rdata (csr_rdata),
        .mtvec     (mtvec),
        .mepc      (mepc)
    );

    always_comb begin
        if (mret) begin
            next_pc = mepc;
        end else if (ecall) begin
            next_pc = mtvec;
        end else if (jump) begin
            next_pc = jalr ? {alu_result[XLEN-1:1], 1'b0} : alu_result;
        end else if (branch && branch_taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = mem_rdata;
            WB_PC4:  wb_data = pc_plus4;
            WB_CSR:  wb_data = csr_rdata;   // old CSR value
            default: wb_data = alu_result;
        endcase
    end

    // EBREAK leaves pc on itself so the halted core keeps fetching the same word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            if (!ebreak) pc <= next_pc;
            halted <= ebreak;
        end
    end

    assign imem_addr    = pc;
    assign retire_pc    = pc;
    assign retire_valid = active;
    assign wb_en        = reg_wen && active;
    assign wb_rd        = rd;
    assign exit_code    = halted ? a0_data : '0;

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

    a_no_illegal: assert property (@(posedge clk) disable iff (!rst_n)
        !halted |-> !illegal);

endmodule

//--- tb_cpu_core.sv
`timescale 1ns/10ps

module tb_cpu_core import rv_pkg::*; ();

    localparam int PROG_WORDS     = 64;
    localparam int TIMEOUT_CYCLES = 500;
    localparam int HALT_WATCH     = 5;

    logic            clk = 1'b0;
    logic            rst_n;
    logic [XLEN-1:0] imem_data;
    logic [XLEN-1:0] imem_addr;
    logic [XLEN-1:0] retire_pc;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] exit_code;
    logic            retire_valid;
    logic            wb_en;
    logic            halted;
    logic [4:0]      wb_rd;

    logic [XLEN-1:0] prog [PROG_WORDS];
    logic [XLEN-1:0] exp_pc [$];
    logic            exp_en [$];
    logic [4:0]      exp_rd [$];
    logic [XLEN-1:0] exp_val [$];
    logic [XLEN-1:0] exp_exit;
    int              rec_idx;
    int              cycles;

    cpu_core cpu_core_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_data    (imem_data),
        .imem_addr    (imem_addr),
        .retire_pc    (retire_pc),
        .wb_data      (wb_data),
        .exit_code    (exit_code),
        .retire_valid (retire_valid),
        .wb_en        (wb_en),
        .halted       (halted),
        .wb_rd        (wb_rd)
    );

    always #5 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] expected);
        if (got !== expected) begin
            stop_run($sformatf("FAIL at %0d ns: %s is %08h, expected %08h",
                               $time, what, got, expected));
        end
    endtask

    task automatic check_reg(input string what, input logic [4:0] got, input logic [4:0] expected);
        if (got !== expected) begin
            stop_run($sformatf("FAIL at %0d ns: %s is x%0d, expected x%0d",
                               $time, what, got, expected));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            stop_run($sformatf("FAIL at %0d ns: %s is %b, expected %b", $time, what, got, expected));
        end
    endtask

    // unused program words hold addi x0, x0, index so a stray fetch is traceable
    task automatic load_patterns();
        int               fd;
        int               code;
        logic [7:0]       tag;
        logic [8*120-1:0] line;
        logic [XLEN-1:0]  f_addr;
        logic [XLEN-1:0]  f_word;
        logic [XLEN-1:0]  f_en;
        logic [XLEN-1:0]  f_rd;
        logic [XLEN-1:0]  f_val;
        logic [XLEN-1:0]  offset;
        logic             exit_seen;
        exit_seen = 1'b0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = {12'(i), 20'h00013};
        end
        fd = $fopen("cpu_core_patterns.txt", "r");
        if (fd == 0) stop_run("cannot open cpu_core_patterns.txt");
        code = $fscanf(fd, " %c", tag);
        while (code == 1) begin
            case (tag)
                "#": code = $fgets(line, fd);
                "P": begin
                    code   = $fscanf(fd, " %h %h", f_addr, f_word);
                    offset = f_addr - RESET_PC;
                    if (code != 2 || offset >= 32'(PROG_WORDS * 4)) begin
                        stop_run("a program line in the pattern file is malformed or out of range");
                    end
                    prog[offset[7:2]] = f_word;
                end
                "E": begin
                    code = $fscanf(fd, " %h %d %d %h", f_addr, f_en, f_rd, f_val);
                    if (code != 4) stop_run("a retire line in the pattern file is malformed");
                    exp_pc.push_back(f_addr);
                    exp_en.push_back(f_en[0]);
                    exp_rd.push_back(f_rd[4:0]);
                    exp_val.push_back(f_val);
                end
                "X": begin
                    code = $fscanf(fd, " %h", exp_exit);
                    if (code != 1) stop_run("the exit code line in the pattern file is malformed");
                    exit_seen = 1'b1;
                end
                default: stop_run($sformatf("unknown line tag %c in the pattern file", tag));
            endcase
            code = $fscanf(fd, " %c", tag);
        end
        $fclose(fd);
        if (exp_pc.size() == 0 || !exit_seen) begin
            stop_run("the pattern file holds no retire records or no exit code");
        end
    endtask

    function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] offset;
        logic [XLEN-1:0] word;
        offset = addr - RESET_PC;
        word   = 32'h0000_0013;   // a nop outside the program
        if (!$isunknown(addr) && offset < 32'(PROG_WORDS * 4)) begin
            word = prog[offset[7:2]];
        end
        return word;
    endfunction

    task automatic check_retire();
        string tag;
        if (rec_idx >= exp_pc.size()) begin
            stop_run($sformatf("the instruction at pc %08h retired after the last expected record",
                               retire_pc));
        end
        tag = $sformatf("retire %0d", rec_idx);
        if (rec_idx == 0) check_word({tag, " first pc"}, retire_pc, RESET_PC);
        check_word({tag, " pc"}, retire_pc, exp_pc[rec_idx]);
        check_word({tag, " imem_addr"}, imem_addr, exp_pc[rec_idx]);
        check_flag({tag, " wb_en"}, wb_en, exp_en[rec_idx]);
        if (exp_en[rec_idx]) begin   // rd and data only mean something with a write
            check_reg({tag, " wb_rd"}, wb_rd, exp_rd[rec_idx]);
            check_word({tag, " wb_data"}, wb_data, exp_val[rec_idx]);
        end
        rec_idx++;
    endtask

    // instruction fetch answers the pc of the current cycle
    initial begin
        imem_data = 32'h0000_0013;
        forever begin
            @(posedge clk);
            #1;
            imem_data = fetch_word(imem_addr);
        end
    end

    initial begin
        rst_n   = 1'b0;
        rec_idx = 0;
        cycles  = 0;
        load_patterns();
        repeat (3) begin
            @(posedge clk);
            #1;
            check_flag("retire_valid during reset", retire_valid, 1'b0);
        end
        rst_n = 1'b1;

        // the retire outputs are stable mid-cycle and hold until the commit edge
        while (!halted) begin
            if (cycles == TIMEOUT_CYCLES) begin
                stop_run($sformatf("timeout, the core did not halt within %0d cycles",
                                   TIMEOUT_CYCLES));
            end
            @(negedge clk);
            cycles++;
            if (retire_valid) check_retire();
        end

        if (rec_idx != exp_pc.size()) begin
            stop_run("the core halted before all expected instructions retired");
        end
        check_word("exit_code", exit_code, exp_exit);
        repeat (HALT_WATCH) begin
            @(negedge clk);
            check_flag("retire_valid while halted", retire_valid, 1'b0);
            check_flag("halted", halted, 1'b1);
        end

        $display("Test OK");
        $finish;
    end

endmodule

//--- cpu_core_patterns.txt
# P <byte address> <instruction word>, program words in hex
# E <pc> <wb_en> <rd> <wb_data>, one per retire in order; X <exit code in a0>
# arithmetic, lui and auipc
P 80000000 123450b7
P 80000004 ffb00113
P 80000008 67808193
P 8000000c 00218233
P 80000010 403102b3
P 80000014 00312333
P 80000018 003133b3
P 8000001c 40115413
P 80000020 01c15493
P 80000024 00419593
P 80000028 0ff1c613
P 8000002c 00118013
P 80000030 00001697
# stores and loads at the data memory base
P 80000034 80001737
P 80000038 00372023
P 8000003c 00271123
P 80000040 00c700a3
P 80000044 00072783
P 80000048 00271803
P 8000004c 00075883
P 80000050 00170903
P 80000054 00174983
# branches and jumps, the addi x20 words must never retire
P 80000058 00030463
P 8000005c 00031463
P 80000060 00100a13
P 80000064 00c000ef
P 80000068 00200a13
P 8000006c 0080006f
P 80000070 00408ae7
P 80000074 00014463
P 80000078 00300a13
P 8000007c 00317463
P 80000080 00400a13
# trap setup, ecall, return and ebreak
P 80000084 80000b37
P 80000088 0c0b0b13
P 8000008c 305b1bf3
P 80000090 30002c73
P 80000094 00000073
P 80000098 01fc8513
P 8000009c 00100073
# handler at mtvec
P 800000c0 34202cf3
P 800000c4 34102d73
P 800000c8 004d0d13
P 800000cc 341d1073
P 800000d0 30200073
E 80000000 1 1 12345000
E 80000004 1 2 fffffffb
E 80000008 1 3 12345678
E 8000000c 1 4 12345673
E 80000010 1 5 edcba983
E 80000014 1 6 00000001
E 80000018 1 7 00000000
E 8000001c 1 8 fffffffd
E 80000020 1 9 0000000f
E 80000024 1 11 23456780
E 80000028 1 12 12345687
E 8000002c 0 0 00000000
E 80000030 1 13 80001030
E 80000034 1 14 80001000
E 80000038 0 0 00000000
E 8000003c 0 0 00000000
E 80000040 0 0 00000000
E 80000044 1 15 fffb8778
E 80000048 1 16 fffffffb
E 8000004c 1 17 00008778
E 80000050 1 18 ffffff87
E 80000054 1 19 00000087
E 80000058 0 0 00000000
E 8000005c 0 0 00000000
E 80000064 1 1 80000068
E 80000070 1 21 80000074
E 8000006c 0 0 00000000
E 80000074 0 0 00000000
E 8000007c 0 0 00000000
E 80000084 1 22 80000000
E 80000088 1 22 800000c0
E 8000008c 1 23 00000000
E 80000090 1 24 00001800
E 80000094 0 0 00000000
E 800000c0 1 25 0000000b
E 800000c4 1 26 80000094
E 800000c8 1 26 80000098
E 800000cc 0 0 00000000
E 800000d0 0 0 00000000
E 80000098 1 10 0000002a
E 8000009c 0 0 00000000
X 0000002a

//--- cpu_core.f
rv_pkg.sv
instr_decode.sv
reg_file.sv
exec_unit.sv
data_mem.sv
csr_unit.sv
cpu_core.sv
tb_cpu_core.sv

//--- Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --assert --timescale 1ns/10ps
LINT_FLAGS := --lint-only --timing --timescale 1ns/10ps
TOP        := tb_cpu_core
FILELIST   := cpu_core.f
BIN        := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^Test OK$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
